// ==== rtl/mem_subsys_config.svh ====
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// word width of the data path
`define MEM_DATA_W 32

// number of words in the data memory
`define MEM_DEPTH 4096

// word index width, log2 of the depth
`define MEM_IDX_W 12

// byte address width seen by the requester
// two low bits select a byte, the index sits above them
`define MEM_ADDR_W 16

`endif

// ==== rtl/mem_pkg.sv ====
`include "mem_subsys_config.svh"

package mem_pkg;

  // one data word
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;

  // byte address from the requester
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

  // word index into the memory array
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t;

  // access kind
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  // response code returned with ack
  // misaligned outranks out of range
  typedef enum logic [1:0] {
    st_ok           = 2'd0,
    st_misaligned   = 2'd1,
    st_out_of_range = 2'd2
  } mem_status_e;

endpackage

// ==== rtl/mem_addr_check.sv ====
`timescale 1ns/1ps

`include "mem_subsys_config.svh"

module mem_addr_check (
  input  mem_pkg::mem_addr_t   addr,
  output mem_pkg::mem_idx_t    idx,
  output mem_pkg::mem_status_e status
);

  import mem_pkg::*;

  // byte lane bits, must be zero for a word access
  logic [1:0] byte_sel;

  // anything above the index field means past the end
  mem_addr_t  high_bits;

  logic       misaligned;
  logic       out_of_range;

  assign byte_sel   = addr[1:0];
  // shift out lane and index, what remains is the overflow part
  assign high_bits  = addr >> (`MEM_IDX_W + 2);

  assign misaligned   = (byte_sel != 2'b00);
  assign out_of_range = (high_bits != '0);

  // index field sits right above the byte lanes
  assign idx = addr[`MEM_IDX_W+1:2];

  // classification, alignment checked first
  always_comb begin
    if (misaligned) begin
      status = st_misaligned;
    end else if (out_of_range) begin
      status = st_out_of_range;
    end else begin
      status = st_ok;
    end
  end

endmodule

// ==== rtl/mem_req_ctrl.sv ====
`timescale 1ns/1ps

module mem_req_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  mem_pkg::mem_op_e     op,
  input  mem_pkg::mem_idx_t    idx,
  input  mem_pkg::mem_status_e chk_status,
  input  mem_pkg::mem_word_t   wdata,
  input  mem_pkg::mem_word_t   dout,
  output logic                 ack,
  output mem_pkg::mem_status_e status,
  output mem_pkg::mem_word_t   rdata,
  output logic                 enable_dm,
  output logic                 enable_fetch,
  output logic                 enable_write,
  output mem_pkg::mem_idx_t    mem_idx,
  output mem_pkg::mem_word_t   din
);

  import mem_pkg::*;

  // idle    waiting for req
  // access  strobes on, memory acts at the next edge
  // settle  load data now on dout
  // respond ack high until req drops
  typedef enum logic [1:0] {
    s_idle    = 2'd0,
    s_access  = 2'd1,
    s_settle  = 2'd2,
    s_respond = 2'd3
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // request captured at the req edge
  mem_op_e     req_op;
  mem_status_e req_status;
  mem_idx_t    req_idx;
  mem_word_t   req_wdata;

  // request is good and wants the memory
  logic        go_access;

  // load that actually touched the memory
  logic        load_hit;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        // new request only once the previous ack is gone
        if (req) begin
          state_d = s_access;
        end
      end
      s_access: begin
        state_d = s_settle;
      end
      s_settle: begin
        state_d = s_respond;
      end
      s_respond: begin
        // hold the answer while the requester keeps req high
        if (!req) begin
          state_d = s_idle;
        end
      end
      default: begin
        state_d = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= s_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // whole request latched in one go at the req edge
  always_ff @(posedge clk) begin
    if (rst) begin
      req_op     <= op_load;
      req_status <= st_ok;
      req_idx    <= '0;
      req_wdata  <= '0;
    end else if (state_q == s_idle && req) begin
      req_op     <= op;
      req_status <= chk_status;
      req_idx    <= idx;
      req_wdata  <= wdata;
    end
  end

  // strobes live for the single access cycle
  // error requests leave the memory alone
  assign go_access    = (state_q == s_access) && (req_status == st_ok);
  assign enable_dm    = go_access;
  assign enable_fetch = go_access && (req_op == op_load);
  assign enable_write = go_access && (req_op == op_store);

  assign mem_idx = req_idx;
  assign din     = req_wdata;

  // stores and errors answer with zero
  assign load_hit = (req_op == op_load) && (req_status == st_ok);

  // response registers, updated on the settle to respond edge
  always_ff @(posedge clk) begin
    if (rst) begin
      status <= st_ok;
      rdata  <= '0;
    end else if (state_q == s_settle) begin
      status <= req_status;
      rdata  <= load_hit ? dout : '0;
    end
  end

  // ack is the respond state itself
  // drops on the first edge that sees req low
  assign ack = (state_q == s_respond);

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ps

`include "mem_subsys_config.svh"

module data_mem (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable_dm,
  input  logic               enable_fetch,
  input  logic               enable_write,
  input  mem_pkg::mem_idx_t  address,
  input  mem_pkg::mem_word_t din,
  output mem_pkg::mem_word_t dout
);

  import mem_pkg::*;

  // word array, one entry per index
  mem_word_t mem_data [`MEM_DEPTH];

  // reset wipes every word and the output register
  // fetch wins over write when both are set
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_DEPTH; i++) begin
        mem_data[i] <= '0;
      end
      dout <= '0;
    end else if (enable_dm) begin
      if (enable_fetch) begin
        // registered read, one edge after the enable
        dout <= mem_data[address];
      end else if (enable_write) begin
        mem_data[address] <= din;
      end
    end
  end

  // dout keeps the last fetched word between accesses

endmodule

// ==== rtl/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  mem_pkg::mem_op_e     op,
  input  mem_pkg::mem_addr_t   addr,
  input  mem_pkg::mem_word_t   wdata,
  output logic                 ack,
  output mem_pkg::mem_status_e status,
  output mem_pkg::mem_word_t   rdata
);

  import mem_pkg::*;

  // checker results, valid while addr is held stable
  mem_idx_t    chk_idx;
  mem_status_e chk_status;

  // controller to memory
  logic        enable_dm;
  logic        enable_fetch;
  logic        enable_write;
  mem_idx_t    mem_idx;
  mem_word_t   mem_din;

  // memory to controller
  mem_word_t   mem_dout;

  // address decode and classification
  mem_addr_check addr_check_i (
    .addr   (addr),
    .idx    (chk_idx),
    .status (chk_status)
  );

  // handshake and strobe sequencing
  mem_req_ctrl req_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .op           (op),
    .idx          (chk_idx),
    .chk_status   (chk_status),
    .wdata        (wdata),
    .dout         (mem_dout),
    .ack          (ack),
    .status       (status),
    .rdata        (rdata),
    .enable_dm    (enable_dm),
    .enable_fetch (enable_fetch),
    .enable_write (enable_write),
    .mem_idx      (mem_idx),
    .din          (mem_din)
  );

  // word storage
  data_mem data_mem_i (
    .clk          (clk),
    .rst          (rst),
    .enable_dm    (enable_dm),
    .enable_fetch (enable_fetch),
    .enable_write (enable_write),
    .address      (mem_idx),
    .din          (mem_din),
    .dout         (mem_dout)
  );

endmodule

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

`include "mem_subsys_config.svh"

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int RESET_CYCLES   = 16;

  // falling edges from driving req until ack is seen high
  // req sampled at the next rising edge, ack two edges after that
  localparam int RISE_EDGES = 3;

  // falling edges from dropping req until ack is seen low
  localparam int FALL_EDGES = 1;

  logic        clk = 1'b0;
  logic        rst;
  logic        req;
  mem_op_e     op;
  mem_addr_t   addr;
  mem_word_t   wdata;
  logic        ack;
  mem_status_e status;
  mem_word_t   rdata;

  // expected memory contents, follows every good store
  mem_word_t model_mem [`MEM_DEPTH];

  integer seed      = 32'h27c8;
  integer err_count = 0;
  integer vec_count = 0;
  bit     timed_out = 1'b0;

  mem_subsys dut_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .op     (op),
    .addr   (addr),
    .wdata  (wdata),
    .ack    (ack),
    .status (status),
    .rdata  (rdata)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // reset pulse, model cleared along with the memory
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    req <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      model_mem[i] = '0;
    end
  endtask

  // sample at falling edges until ack reaches level
  // cycles counts the edges after the first one
  task automatic wait_ack(input logic level, input string name, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (ack !== level && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== level) begin
      $display("%s: ack did not go to %0b within %0d cycles", name, level, TIMEOUT_CYCLES);
      err_count++;
      timed_out = 1'b1;
    end
  endtask

  // one full four-phase handshake
  // random flag: store gets $random data, load expects the model word
  task automatic run_access(input string name, input logic random_flag, input mem_op_e v_op,
                            input mem_addr_t v_addr, input mem_word_t v_wdata,
                            input mem_status_e exp_status, input mem_word_t exp_rdata,
                            input int hold);
    mem_word_t   store_data;
    mem_word_t   exp_data;
    mem_idx_t    word_idx;
    int          edges;
    // word index is the field right above the byte lanes
    word_idx   = v_addr[`MEM_IDX_W+1:2];
    store_data = v_wdata;
    exp_data   = exp_rdata;
    if (random_flag) begin
      if (v_op == op_store) begin
        store_data = $random(seed);
      end else begin
        exp_data = model_mem[word_idx];
      end
    end
    // previous response must be gone before the new req
    @(negedge clk);
    if (ack !== 1'b0) begin
      $display("%s: ack high before req was raised", name);
      err_count++;
    end
    @(posedge clk);
    req   <= 1'b1;
    op    <= v_op;
    addr  <= v_addr;
    wdata <= store_data;
    wait_ack(1'b1, name, edges);
    if (!timed_out) begin
      // ack must come neither early nor late
      if (edges != RISE_EDGES) begin
        $display("ERR %s ack rise: expected %0d, actual %0d", name, RISE_EDGES, edges);
        err_count++;
      end
      if (status !== exp_status) begin
        $display("ERR %s status: expected %0d, actual %0d", name, exp_status, status);
        err_count++;
      end
      if (rdata !== exp_data) begin
        $display("ERR %s rdata: expected %h, actual %h", name, exp_data, rdata);
        err_count++;
      end
      // back-pressure, response must hold while req stays up
      for (int c = 0; c < hold; c++) begin
        @(negedge clk);
        if (ack !== 1'b1) begin
          $display("%s: ack dropped while req was still high", name);
          err_count++;
        end
        if (status !== exp_status) begin
          $display("ERR %s status hold: expected %0d, actual %0d", name, exp_status, status);
          err_count++;
        end
        if (rdata !== exp_data) begin
          $display("ERR %s rdata hold: expected %h, actual %h", name, exp_data, rdata);
          err_count++;
        end
      end
      @(posedge clk);
      req <= 1'b0;
      wait_ack(1'b0, name, edges);
      // ack falls on the first edge that samples req low
      if (!timed_out && edges != FALL_EDGES) begin
        $display("ERR %s ack fall: expected %0d, actual %0d", name, FALL_EDGES, edges);
        err_count++;
      end
      // only good stores change memory
      if (!timed_out && v_op == op_store && exp_status == st_ok) begin
        model_mem[word_idx] = store_data;
      end
    end
  endtask

  initial begin
    integer         fd;
    integer         n_chars;
    integer         n_fields;
    reg [8*128-1:0] line_buf;
    reg [8*16-1:0]  name_buf;
    logic [31:0]    v_kind;
    logic [31:0]    v_op;
    logic [31:0]    v_addr;
    logic [31:0]    v_wdata;
    logic [31:0]    v_st;
    logic [31:0]    v_rdata;
    logic [31:0]    v_hold;
    string          name;
    rst   <= 1'b1;
    req   <= 1'b0;
    op    <= op_load;
    addr  <= '0;
    wdata <= '0;
    apply_reset();
    fd = $fopen("testbench/mem_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/mem_vectors.txt");
      err_count++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        line_buf = '0;
        n_chars  = $fgets(line_buf, fd);
        n_fields = 0;
        if (n_chars > 0) begin
          n_fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h", name_buf, v_kind, v_op,
                             v_addr, v_wdata, v_st, v_rdata, v_hold);
        end
        // comment and blank lines fall through here
        if (n_fields == 8) begin
          name = string'(name_buf);
          vec_count++;
          if (v_kind == 32'd2) begin
            // mid-run reset, ack must be low afterwards
            apply_reset();
            @(negedge clk);
            if (ack !== 1'b0) begin
              $display("%s: ack high after reset", name);
              err_count++;
            end
          end else begin
            run_access(name, v_kind[0], mem_op_e'(v_op[0]), v_addr[`MEM_ADDR_W-1:0],
                       v_wdata, mem_status_e'(v_st[1:0]), v_rdata, v_hold);
          end
        end
      end
      $fclose(fd);
    end
    if (vec_count == 0) begin
      $display("no vector lines were read");
      err_count++;
    end
    $display("errors: %0d, vectors run: %0d", err_count, vec_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/mem_vectors.txt ====
# name kind(0 fixed, 1 random store or model load, 2 reset) op(0 load, 1 store) addr wdata
# expected status(0 ok, 1 misaligned, 2 out of range) expected rdata, extra hold cycles (hex)
rst_ld0      0 0 0000 00000000 0 00000000 0
rst_ld1      0 0 0004 00000000 0 00000000 0
rst_ldtop    0 0 3ffc 00000000 0 00000000 0
rst_ldmid    0 0 1230 00000000 0 00000000 2
st_idx0      0 1 0000 a5a5a5a5 0 00000000 0
st_top       0 1 3ffc 5a5a5a5a 0 00000000 3
st_mid       0 1 1230 deadbeef 0 00000000 0
st_four      0 1 0004 01234567 0 00000000 0
ld_idx0      0 0 0000 00000000 0 a5a5a5a5 0
ld_top       0 0 3ffc 00000000 0 5a5a5a5a 0
ld_mid       0 0 1230 00000000 0 deadbeef 5
ld_four      0 0 0004 00000000 0 01234567 0
ovw_mid      0 1 1230 cafef00d 0 00000000 0
ld_ovw       0 0 1230 00000000 0 cafef00d 0
mis_st1      0 1 0005 ffffffff 1 00000000 0
mis_st2      0 1 0006 ffffffff 1 00000000 2
mis_st3      0 1 0007 ffffffff 1 00000000 0
mis_chk      0 0 0004 00000000 0 01234567 0
mis_ld       0 0 1231 00000000 1 00000000 4
oor_st14     0 1 4000 bbbbbbbb 2 00000000 0
oor_st15     0 1 bffc cccccccc 2 00000000 1
oor_ld       0 0 c004 00000000 2 00000000 0
alias_idx0   0 0 0000 00000000 0 a5a5a5a5 0
alias_top    0 0 3ffc 00000000 0 5a5a5a5a 0
both_err     0 1 4001 eeeeeeee 1 00000000 0
rnd_st0      1 1 0100 00000000 0 00000000 0
rnd_st1      1 1 0204 00000000 0 00000000 0
rnd_st2      1 1 2ff8 00000000 0 00000000 3
rnd_st3      1 1 0100 00000000 0 00000000 0
rnd_ld0      1 0 0100 00000000 0 00000000 0
rnd_ld1      1 0 0204 00000000 0 00000000 2
rnd_ld2      1 0 2ff8 00000000 0 00000000 0
mid_reset    2 0 0000 00000000 0 00000000 0
post_ld_mid  0 0 1230 00000000 0 00000000 0
post_ld_top  0 0 3ffc 00000000 0 00000000 0
post_ld_rnd  1 0 0204 00000000 0 00000000 0
post_st      0 1 0008 13579bdf 0 00000000 0
post_ld      0 0 0008 00000000 0 13579bdf 0

// ==== src.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_addr_check.sv
rtl/mem_req_ctrl.sv
rtl/data_mem.sv
rtl/mem_subsys.sv
testbench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the data memory testbench with Verilator and run it
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

TOP=tb_mem_subsys
OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing -Wno-fatal \
  -f src.f --top-module "$TOP" --Mdir "$OBJ_DIR" -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "no verdict line found in $LOG"
  exit 1
fi
exit 0
